// ==== files.f ====
logic/tinyrv1_pkg.sv
logic/proc_regfile.sv
logic/proc_dpath.sv
logic/proc_ctrl.sv
logic/proc_top.sv
verif/proc_checker.sv
verif/proc_tb.sv

// ==== logic/proc_ctrl.sv ====
`timescale 1ns/1ns

module proc_ctrl (
  input  logic                       clk,
  input  logic                       arst_n,
  input  tinyrv1_pkg::dpath_status_t d2c,
  output tinyrv1_pkg::ctrl_sigs_t    c2d,
  output logic                       dmemreq_val,
  output logic                       dmemreq_is_write,
  output logic [4:0]                 rf_waddr_W,
  output logic                       trace_val
);
  import tinyrv1_pkg::*;

  // Decoded attributes of the D instruction
  typedef struct packed {
    logic      rs1_en;
    logic      rs2_en;
    logic      wen;
    logic      op2_imm;
    imm_type_e imm_type;
  } dec_t;

  // What each later stage remembers about its instruction
  typedef struct packed {
    logic                  val;
    inst_op_e              op;
    logic                  wen;
    logic [reg_addr_w-1:0] rd;
  } stage_t;

  inst_op_e              op_D;
  dec_t                  dec_D;
  logic [reg_addr_w-1:0] rs1_D;
  logic [reg_addr_w-1:0] rs2_D;
  logic [reg_addr_w-1:0] rd_D;
  logic                  wen_D;
  logic                  val_D;
  logic                  stall_D;
  logic                  jump_D;
  logic                  br_taken_X;
  stage_t                stg_X;
  stage_t                stg_M;
  stage_t                stg_W;

  // ==========================================================
  // Decode
  // ==========================================================

  always_comb begin
    casez (d2c.inst_D)
      32'b0000000_?????_?????_000_?????_0110011: op_D = op_add;
      32'b0000001_?????_?????_000_?????_0110011: op_D = op_mul;
      32'b???????_?????_?????_000_?????_0010011: op_D = op_addi;
      32'b???????_?????_?????_010_?????_0000011: op_D = op_lw;
      32'b???????_?????_?????_010_?????_0100011: op_D = op_sw;
      32'b???????_?????_?????_???_?????_1101111: op_D = op_jal;
      32'b000000000000_?????_000_00000_1100111:  op_D = op_jr;
      32'b???????_?????_?????_001_?????_1100011: op_D = op_bne;
      default:                                   op_D = op_nop;
    endcase
  end

  always_comb begin
    case (op_D)
      op_add, op_mul: dec_D = '{1'b1, 1'b1, 1'b1, 1'b0, imm_i};
      op_addi, op_lw: dec_D = '{1'b1, 1'b0, 1'b1, 1'b1, imm_i};
      op_sw:          dec_D = '{1'b1, 1'b1, 1'b0, 1'b1, imm_s};
      op_jal:         dec_D = '{1'b0, 1'b0, 1'b1, 1'b0, imm_j};
      op_jr:          dec_D = '{1'b1, 1'b0, 1'b0, 1'b0, imm_i};
      op_bne:         dec_D = '{1'b1, 1'b1, 1'b0, 1'b0, imm_b};
      default:        dec_D = '{1'b0, 1'b0, 1'b0, 1'b0, imm_i};
    endcase
  end

  assign rs1_D = d2c.inst_D[rs1_lsb +: reg_addr_w];
  assign rs2_D = d2c.inst_D[rs2_lsb +: reg_addr_w];
  assign rd_D  = d2c.inst_D[rd_lsb +: reg_addr_w];
  assign wen_D = dec_D.wen && (rd_D != '0);

  // ==========================================================
  // Hazards
  // ==========================================================

  assign br_taken_X = stg_X.val && (stg_X.op == op_bne) && !d2c.eq_X;

  // Load result is not ready until M
  assign stall_D = val_D && stg_X.val && (stg_X.op == op_lw) && stg_X.wen &&
                   ((dec_D.rs1_en && (rs1_D == stg_X.rd)) ||
                    (dec_D.rs2_en && (rs2_D == stg_X.rd)));

  assign jump_D = val_D && ((op_D == op_jal) || (op_D == op_jr)) && !stall_D && !br_taken_X;

  // Youngest producer wins
  function automatic byp_sel_e pick_byp(input logic [reg_addr_w-1:0] rs);
    if (stg_X.val && stg_X.wen && (stg_X.rd == rs)) return byp_x;
    if (stg_M.val && stg_M.wen && (stg_M.rd == rs)) return byp_m;
    if (stg_W.val && stg_W.wen && (stg_W.rd == rs)) return byp_w;
    return byp_rf;
  endfunction

  // ==========================================================
  // Stage tracking
  // ==========================================================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      val_D <= 1'b0;
      stg_X <= '0;
      stg_M <= '0;
      stg_W <= '0;
    end else begin
      if (!stall_D) begin
        val_D <= !(jump_D || br_taken_X);
      end
      stg_X <= '{val: val_D && !stall_D && !br_taken_X, op: op_D, wen: wen_D, rd: rd_D};
      stg_M <= stg_X;
      stg_W <= stg_M;
    end
  end

  always_comb begin
    c2d.reg_en_F = !stall_D;
    c2d.reg_en_D = !stall_D;
    if (br_taken_X) begin
      c2d.pc_sel = pc_branch_x;
    end else if (jump_D) begin
      c2d.pc_sel = (op_D == op_jal) ? pc_jump_d : pc_jr_d;
    end else begin
      c2d.pc_sel = pc_plus4;
    end
    c2d.imm_type       = dec_D.imm_type;
    c2d.op1_byp_sel    = pick_byp(rs1_D);
    c2d.op2_byp_sel    = pick_byp(rs2_D);
    c2d.op2_sel_imm    = dec_D.op2_imm;
    c2d.alu_fn_add     = (stg_X.op != op_bne);
    c2d.result_sel_mul = (stg_X.op == op_mul);
    c2d.wb_sel_mem     = (stg_M.op == op_lw);
    c2d.rf_wen_W       = stg_W.val && stg_W.wen;
    c2d.rf_waddr_W     = stg_W.rd;
    c2d.squash_D       = br_taken_X;
  end

  assign dmemreq_val      = stg_M.val && ((stg_M.op == op_lw) || (stg_M.op == op_sw));
  assign dmemreq_is_write = (stg_M.op == op_sw);
  assign rf_waddr_W       = stg_W.rd;
  assign trace_val        = c2d.rf_wen_W;

endmodule

// ==== logic/proc_dpath.sv ====
`timescale 1ns/1ns

module proc_dpath (
  input  logic                       clk,
  input  logic                       arst_n,
  input  tinyrv1_pkg::ctrl_sigs_t    c2d,
  output tinyrv1_pkg::dpath_status_t d2c,
  output tinyrv1_pkg::mem_req_t      imemreq,
  input  logic [31:0]                imemresp_data,
  output logic [31:0]                dmemreq_addr,
  output logic [31:0]                dmemreq_wdata,
  input  logic [31:0]                dmemresp_rdata,
  output logic [4:0]                 rf_raddr0,
  output logic [4:0]                 rf_raddr1,
  input  logic [31:0]                rf_rdata0,
  input  logic [31:0]                rf_rdata1,
  output logic [31:0]                rf_wdata
);
  import tinyrv1_pkg::*;

  // Results fed back to the bypass muxes
  logic [31:0] result_X_next;
  logic [31:0] result_M_next;
  logic [31:0] result_W;

  logic [31:0] pc_F;
  logic [31:0] pc_inc_F;
  logic [31:0] pc_next;
  logic [31:0] inst_D;
  logic [31:0] pc_D;
  logic [31:0] imm_D;
  logic [31:0] targ_D;
  logic [31:0] op1_byp;
  logic [31:0] op2_byp;
  logic        link_D;
  logic [31:0] op1_D;
  logic [31:0] op2_D;
  logic [31:0] op1_X;
  logic [31:0] op2_X;
  logic [31:0] sdata_X;
  logic [31:0] br_targ_X;
  logic [31:0] alu_out;
  logic [31:0] mul_out;
  logic [31:0] result_M;
  logic [31:0] sdata_M;

  // ==========================================================
  // Stage F
  // ==========================================================

  assign pc_inc_F = pc_F + 32'd4;

  always_comb begin
    case (c2d.pc_sel)
      pc_jump_d:   pc_next = targ_D;
      pc_jr_d:     pc_next = op1_byp;
      pc_branch_x: pc_next = br_targ_X;
      default:     pc_next = pc_inc_F;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc_F <= reset_pc;
    end else if (c2d.reg_en_F) begin
      pc_F <= pc_next;
    end
  end

  // Fetch every cycle, a held PC simply refetches
  assign imemreq = '{val: 1'b1, is_write: 1'b0, addr: pc_F, wdata: 32'd0};

  always_ff @(posedge clk) begin
    if (c2d.reg_en_D) begin
      inst_D <= imemresp_data;
      pc_D   <= pc_F;
    end
  end

  // ==========================================================
  // Stage D
  // ==========================================================

  assign rf_raddr0 = inst_D[rs1_lsb +: reg_addr_w];
  assign rf_raddr1 = inst_D[rs2_lsb +: reg_addr_w];

  always_comb begin
    case (c2d.imm_type)
      imm_s:   imm_D = {{20{inst_D[31]}}, inst_D[31:25], inst_D[11:7]};
      imm_b:   imm_D = {{20{inst_D[31]}}, inst_D[7], inst_D[30:25], inst_D[11:8], 1'b0};
      imm_j:   imm_D = {{12{inst_D[31]}}, inst_D[19:12], inst_D[20], inst_D[30:21], 1'b0};
      default: imm_D = {{20{inst_D[31]}}, inst_D[31:20]};
    endcase
  end

  // jal target now, bne target carried into X
  assign targ_D = pc_D + imm_D;

  function automatic logic [31:0] byp_mux(input byp_sel_e sel, input logic [31:0] rf_val);
    case (sel)
      byp_x:   return result_X_next;
      byp_m:   return result_M_next;
      byp_w:   return result_W;
      default: return rf_val;
    endcase
  endfunction

  always_comb begin
    op1_byp = byp_mux(c2d.op1_byp_sel, rf_rdata0);
    op2_byp = byp_mux(c2d.op2_byp_sel, rf_rdata1);
  end

  // Only jal is J-type; its link pc+4 goes through the X adder
  assign link_D = (c2d.imm_type == imm_j);
  assign op1_D  = link_D ? pc_D : op1_byp;
  assign op2_D  = link_D ? 32'd4 : (c2d.op2_sel_imm ? imm_D : op2_byp);

  always_ff @(posedge clk) begin
    if (c2d.squash_D) begin
      op1_X     <= 32'd0;
      op2_X     <= 32'd0;
      sdata_X   <= 32'd0;
      br_targ_X <= 32'd0;
    end else begin
      op1_X     <= op1_D;
      op2_X     <= op2_D;
      sdata_X   <= op2_byp;
      br_targ_X <= targ_D;
    end
  end

  // ==========================================================
  // Stage X
  // ==========================================================

  assign alu_out = c2d.alu_fn_add ? (op1_X + op2_X) : {31'd0, op1_X == op2_X};
  assign mul_out = op1_X * op2_X;

  assign result_X_next = c2d.result_sel_mul ? mul_out : alu_out;

  assign d2c = '{inst_D: inst_D, eq_X: alu_out[0]};

  always_ff @(posedge clk) begin
    result_M <= result_X_next;
    sdata_M  <= sdata_X;
  end

  // ==========================================================
  // Stage M and W
  // ==========================================================

  assign dmemreq_addr  = result_M;
  assign dmemreq_wdata = sdata_M;

  assign result_M_next = c2d.wb_sel_mem ? dmemresp_rdata : result_M;

  always_ff @(posedge clk) begin
    result_W <= result_M_next;
  end

  assign rf_wdata = result_W;

endmodule

// ==== logic/proc_regfile.sv ====
`timescale 1ns/1ns

module proc_regfile (
  input  logic        clk,
  input  logic        wen,
  input  logic [4:0]  waddr,
  input  logic [31:0] wdata,
  input  logic [4:0]  raddr0,
  input  logic [4:0]  raddr1,
  output logic [31:0] rdata0,
  output logic [31:0] rdata1
);

  // No storage behind x0
  logic [31:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (wen && (waddr != 5'd0)) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 always reads as zero
  assign rdata0 = (raddr0 == 5'd0) ? 32'd0 : regs[raddr0];
  assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];

endmodule

// ==== logic/proc_top.sv ====
`timescale 1ns/1ns

module proc_top (
  input  logic                  clk,
  input  logic                  arst_n,
  output tinyrv1_pkg::mem_req_t imemreq,
  input  logic [31:0]           imemresp_data,
  output tinyrv1_pkg::mem_req_t dmemreq,
  input  logic [31:0]           dmemresp_rdata,
  output logic                  trace_val,
  output logic [4:0]            trace_waddr,
  output logic [31:0]           trace_data
);
  import tinyrv1_pkg::*;

  ctrl_sigs_t    c2d;
  dpath_status_t d2c;
  logic          dmemreq_val;
  logic          dmemreq_is_write;
  logic [31:0]   dmemreq_addr;
  logic [31:0]   dmemreq_wdata;
  logic [4:0]    rf_raddr0;
  logic [4:0]    rf_raddr1;
  logic [31:0]   rf_rdata0;
  logic [31:0]   rf_rdata1;
  logic [31:0]   rf_wdata;

  proc_ctrl i_ctrl (
    .clk              (clk),
    .arst_n           (arst_n),
    .d2c              (d2c),
    .c2d              (c2d),
    .dmemreq_val      (dmemreq_val),
    .dmemreq_is_write (dmemreq_is_write),
    .rf_waddr_W       (trace_waddr),
    .trace_val        (trace_val)
  );

  proc_dpath i_dpath (
    .clk            (clk),
    .arst_n         (arst_n),
    .c2d            (c2d),
    .d2c            (d2c),
    .imemreq        (imemreq),
    .imemresp_data  (imemresp_data),
    .dmemreq_addr   (dmemreq_addr),
    .dmemreq_wdata  (dmemreq_wdata),
    .dmemresp_rdata (dmemresp_rdata),
    .rf_raddr0      (rf_raddr0),
    .rf_raddr1      (rf_raddr1),
    .rf_rdata0      (rf_rdata0),
    .rf_rdata1      (rf_rdata1),
    .rf_wdata       (rf_wdata)
  );

  // Write port is driven straight from the W stage controls
  proc_regfile i_regfile (
    .clk    (clk),
    .wen    (c2d.rf_wen_W),
    .waddr  (c2d.rf_waddr_W),
    .wdata  (rf_wdata),
    .raddr0 (rf_raddr0),
    .raddr1 (rf_raddr1),
    .rdata0 (rf_rdata0),
    .rdata1 (rf_rdata1)
  );

  assign dmemreq = '{val: dmemreq_val, is_write: dmemreq_is_write,
                     addr: dmemreq_addr, wdata: dmemreq_wdata};

  assign trace_data = rf_wdata;

endmodule

// ==== logic/tinyrv1_pkg.sv ====
package tinyrv1_pkg;

  // ==========================================================
  // Constants
  // ==========================================================

  localparam logic [31:0] reset_pc = 32'h0000_0000;

  // Register fields inside an instruction word
  localparam int rs1_lsb    = 15;
  localparam int rs2_lsb    = 20;
  localparam int rd_lsb     = 7;
  localparam int reg_addr_w = 5;

  // ==========================================================
  // Encodings
  // ==========================================================

  typedef enum logic [3:0] {
    op_nop,
    op_add,
    op_addi,
    op_mul,
    op_lw,
    op_sw,
    op_jal,
    op_jr,
    op_bne
  } inst_op_e;

  // Next PC source
  typedef enum logic [1:0] {pc_plus4, pc_jump_d, pc_jr_d, pc_branch_x} pc_sel_e;

  // Operand source for the D stage bypass muxes
  typedef enum logic [1:0] {byp_rf, byp_x, byp_m, byp_w} byp_sel_e;

  typedef enum logic [1:0] {imm_i, imm_s, imm_b, imm_j} imm_type_e;

  // ==========================================================
  // Control, status and memory request bundles
  // ==========================================================

  typedef struct packed {
    logic                  reg_en_F;
    logic                  reg_en_D;
    pc_sel_e               pc_sel;
    imm_type_e             imm_type;
    byp_sel_e              op1_byp_sel;
    byp_sel_e              op2_byp_sel;
    logic                  op2_sel_imm;
    logic                  alu_fn_add;     // 0 selects compare-equal
    logic                  result_sel_mul;
    logic                  wb_sel_mem;
    logic                  rf_wen_W;
    logic [reg_addr_w-1:0] rf_waddr_W;
    logic                  squash_D;
  } ctrl_sigs_t;

  typedef struct packed {
    logic [31:0] inst_D;
    logic        eq_X;
  } dpath_status_t;

  typedef struct packed {
    logic        val;
    logic        is_write;
    logic [31:0] addr;
    logic [31:0] wdata;
  } mem_req_t;

endpackage

// ==== verif/proc_checker.sv ====
`timescale 1ns/1ns

module proc_checker (
  input logic                    clk,
  input logic                    arst_n,
  input tinyrv1_pkg::ctrl_sigs_t c2d,
  input logic                    dmemreq_val,
  input logic                    dmemreq_is_write,
  input logic                    stall_d,
  input logic                    x_val
);
  import tinyrv1_pkg::*;

  // Nothing may be written to memory while the core is held in reset
  a_no_store_in_reset: assert property (
    @(posedge clk) !arst_n |-> !(dmemreq_val && dmemreq_is_write))
    else $error("store issued while arst_n is low");

  // A write at W comes from an instruction that was live in X two cycles before
  a_wen_needs_valid_w: assert property (
    @(posedge clk) disable iff (!arst_n) c2d.rf_wen_W |-> $past(x_val, 2))
    else $error("rf_wen_W high without a valid W stage");

  // A stalled cycle neither squashes nor redirects the fetch
  a_no_squash_on_stall: assert property (
    @(posedge clk) disable iff (!arst_n)
      stall_d |-> (!c2d.squash_D && (c2d.pc_sel == pc_plus4)))
    else $error("squash and stall in the same cycle");

endmodule

bind proc_ctrl proc_checker i_checker (
  .clk              (clk),
  .arst_n           (arst_n),
  .c2d              (c2d),
  .dmemreq_val      (dmemreq_val),
  .dmemreq_is_write (dmemreq_is_write),
  .stall_d          (stall_D),
  .x_val            (stg_X.val)
);

// ==== verif/proc_tb.sv ====
`timescale 1ns/1ns

module proc_tb;
  import tinyrv1_pkg::*;

  localparam int imem_words = 128;
  localparam int dmem_words = 64;
  localparam int wait_limit = 50;

  logic        clk;
  logic        arst_n;
  mem_req_t    imemreq;
  logic [31:0] imemresp_data;
  mem_req_t    dmemreq;
  logic [31:0] dmemresp_rdata;
  logic        trace_val;
  logic [4:0]  trace_waddr;
  logic [31:0] trace_data;

  logic [31:0] imem   [0:imem_words-1];
  logic [31:0] dmem   [0:dmem_words-1];
  logic [31:0] shadow [0:dmem_words-1];

  // Program words and expected write-backs in program order
  logic [31:0] prog     [$];
  string       exp_name [$];
  logic [4:0]  exp_rd   [$];
  logic [31:0] exp_data [$];

  integer seed;
  int     errors;
  int     timeouts;
  int     store_count;
  bit     timed_out;

  proc_top i_dut (
    .clk            (clk),
    .arst_n         (arst_n),
    .imemreq        (imemreq),
    .imemresp_data  (imemresp_data),
    .dmemreq        (dmemreq),
    .dmemresp_rdata (dmemresp_rdata),
    .trace_val      (trace_val),
    .trace_waddr    (trace_waddr),
    .trace_data     (trace_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ==========================================================
  // Instruction encoders
  // ==========================================================

  function automatic logic [31:0] add(input logic [4:0] rd, rs1, rs2);
    return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] mul(input logic [4:0] rd, rs1, rs2);
    return {7'b0000001, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] addi(input logic [4:0] rd, rs1, input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] lw(input logic [4:0] rd, rs1, input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, 7'b0000011};
  endfunction

  function automatic logic [31:0] sw(input logic [4:0] rs2, rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] bne(input logic [4:0] rs1, rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] jr(input logic [4:0] rs1);
    return {12'd0, rs1, 3'b000, 5'd0, 7'b1100111};
  endfunction

  // ==========================================================
  // Memory models answering before the next rising edge
  // ==========================================================

  always @(negedge clk) begin
    if (arst_n && dmemreq.val && dmemreq.is_write) begin
      dmem[dmemreq.addr[7:2]] = dmemreq.wdata;
      store_count++;
    end
    // Fetch request is a read on every cycle out of reset
    if (arst_n) begin
      check_value("imemreq val", 32'd1, imemreq.val);
      check_value("imemreq is_write", 32'd0, imemreq.is_write);
    end
    if (imemreq.addr < imem_words * 4) begin
      imemresp_data = imem[imemreq.addr[8:2]];
    end else begin
      imemresp_data = addi(5'd0, 5'd0, 12'd0);
    end
    dmemresp_rdata = dmem[dmemreq.addr[7:2]];
  end

  task automatic load_program();
    prog = {
      addi(5'd1, 5'd0, 12'd5),        // 0x00
      addi(5'd2, 5'd0, 12'hFFD),      // -3
      addi(5'd3, 5'd0, 12'h7FF),
      addi(5'd4, 5'd0, 12'h800),      // -2048
      add(5'd5, 5'd1, 5'd2),          // 0x10
      add(5'd6, 5'd5, 5'd3),
      add(5'd7, 5'd6, 5'd5),
      add(5'd8, 5'd7, 5'd5),
      mul(5'd9, 5'd8, 5'd2),          // 0x20
      mul(5'd10, 5'd9, 5'd9),
      sw(5'd8, 5'd0, 12'd8),
      lw(5'd11, 5'd0, 12'd8),
      lw(5'd12, 5'd0, 12'd20),        // 0x30
      add(5'd13, 5'd12, 5'd1),        // load-use
      sw(5'd13, 5'd0, 12'd16),
      bne(5'd1, 5'd2, 13'd12),        // taken to 0x48
      addi(5'd14, 5'd0, 12'd99),      // 0x40
      addi(5'd14, 5'd0, 12'd98),
      bne(5'd5, 5'd5, 13'd8),         // not taken
      addi(5'd15, 5'd0, 12'd77),
      addi(5'd16, 5'd15, 12'd1),      // 0x50
      jal(5'd17, 21'd12),             // to 0x60
      addi(5'd18, 5'd0, 12'd55),
      jal(5'd0, 21'd20),              // to 0x70
      addi(5'd19, 5'd0, 12'd44),      // 0x60
      jr(5'd17),                      // back to 0x58
      addi(5'd20, 5'd0, 12'd33),
      addi(5'd20, 5'd0, 12'd32),
      add(5'd21, 5'd19, 5'd18)        // 0x70
    };
    // Spare words are harmless x0 writes carrying their own index
    for (int i = 0; i < imem_words; i++) begin
      imem[i] = addi(5'd0, 5'd0, i[11:0]);
    end
    for (int i = 0; i < prog.size(); i++) begin
      imem[i] = prog[i];
    end
  endtask

  task automatic expect_write(input string name, input logic [4:0] rd, input logic [31:0] data);
    exp_name.push_back(name);
    exp_rd.push_back(rd);
    exp_data.push_back(data);
  endtask

  task automatic build_expected();
    expect_write("addi x1", 5'd1, 32'd5);
    expect_write("addi x2 negative", 5'd2, 32'hFFFF_FFFD);
    expect_write("addi x3 max", 5'd3, 32'd2047);
    expect_write("addi x4 min", 5'd4, 32'hFFFF_F800);
    expect_write("add x5 bypass W", 5'd5, 32'd2);
    expect_write("add x6 bypass X W", 5'd6, 32'd2049);
    expect_write("add x7 bypass X M", 5'd7, 32'd2051);
    expect_write("add x8 bypass X W", 5'd8, 32'd2053);
    expect_write("mul x9", 5'd9, 32'd2053 * 32'hFFFF_FFFD);
    expect_write("mul x10", 5'd10, 32'hFFFF_E7F1 * 32'hFFFF_E7F1);
    expect_write("lw x11 after sw", 5'd11, 32'd2053);
    expect_write("lw x12 preset", 5'd12, shadow[5]);
    expect_write("add x13 load-use", 5'd13, shadow[5] + 32'd5);
    expect_write("addi x15 after bne", 5'd15, 32'd77);
    expect_write("addi x16", 5'd16, 32'd78);
    expect_write("jal x17 link", 5'd17, 32'd88);
    expect_write("addi x19", 5'd19, 32'd44);
    expect_write("addi x18 after jr", 5'd18, 32'd55);
    expect_write("add x21", 5'd21, 32'd99);
    // Memory image once both stores have landed
    shadow[2] = 32'd2053;
    shadow[4] = shadow[5] + 32'd5;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Mismatch: %s expected 0x%08h actual 0x%08h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic wait_write(input string name);
    int cycles;
    cycles = 0;
    while (!trace_val && cycles < wait_limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!trace_val) begin
      $display("Timeout: no register write for %s within %0d cycles", name, wait_limit);
      timeouts++;
      timed_out = 1'b1;
    end
  endtask

  // ==========================================================
  // Main sequence
  // ==========================================================

  initial begin
    arst_n         = 1'b0;
    imemresp_data  = 32'd0;
    dmemresp_rdata = 32'd0;
    errors         = 0;
    timeouts       = 0;
    store_count    = 0;
    timed_out      = 1'b0;
    seed           = 32'h3955;
    for (int i = 0; i < dmem_words; i++) begin
      shadow[i] = $random(seed);
      dmem[i]   = shadow[i];
    end
    load_program();
    build_expected();
    repeat (3) @(negedge clk);
    arst_n = 1'b1;

    for (int i = 0; i < exp_rd.size() && !timed_out; i++) begin
      wait_write(exp_name[i]);
      if (!timed_out) begin
        check_value({exp_name[i], " rd"}, exp_rd[i], trace_waddr);
        check_value(exp_name[i], exp_data[i], trace_data);
        @(negedge clk);
      end
    end

    if (!timed_out) begin
      // Squashed slots and trailing filler must never write
      repeat (20) begin
        if (trace_val) begin
          $display("Unexpected register write to x%0d after the last expected one",
                   trace_waddr);
          errors++;
        end
        @(negedge clk);
      end
      check_value("store count", 32'd2, store_count);
      for (int i = 0; i < dmem_words; i++) begin
        check_value($sformatf("dmem word %0d", i), shadow[i], dmem[i]);
      end
    end

    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
